//--- project.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/issue_pkg.sv
rtl/inst_pair_buffer.sv
rtl/pair_decoder.sv
rtl/issue_dispatch.sv
rtl/exec_lane_regs.sv
rtl/dual_issue_top.sv
verif/tb_dual_issue.sv

//--- rtl/dispatch_params.svh
`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Issue front sizing and PC sequencing
//////////////////////////////////////////////////////////////////////

// Entries in the instruction pair buffer, must be a power of two
`define BUF_DEPTH 8

// PC given to the first word pushed after reset
`define RESET_PC 32'h1c00_0000

// Distance between consecutive instruction PCs
`define PC_STEP 32'd4

`endif

//--- rtl/dual_issue_top.sv
`timescale 1ns/100ps

module dual_issue_top (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_inst_valid,
    input  isa_pkg::inst_word_u      i_inst,
    input  logic                     i_exec_stall,
    output logic                     o_inst_ready,
    output logic                     o_lane0_valid,
    output issue_pkg::decoded_inst_t o_lane0_inst,
    output logic                     o_lane1_valid,
    output issue_pkg::decoded_inst_t o_lane1_inst
);
    import isa_pkg::*;
    import issue_pkg::*;

    logic          slot_a_valid;
    inst_word_u    slot_a_word;
    logic [31:0]   slot_a_pc;
    logic          slot_b_valid;
    inst_word_u    slot_b_word;
    logic [31:0]   slot_b_pc;
    decoded_inst_t dec_a;
    decoded_inst_t dec_b;
    issue_cnt_t    issue_cnt;
    logic          issue_a;
    logic          issue_b;

    inst_pair_buffer u_buffer (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_inst_valid   (i_inst_valid),
        .i_inst         (i_inst),
        .i_issue_cnt    (issue_cnt),
        .o_inst_ready   (o_inst_ready),
        .o_slot_a_valid (slot_a_valid),
        .o_slot_a_word  (slot_a_word),
        .o_slot_a_pc    (slot_a_pc),
        .o_slot_b_valid (slot_b_valid),
        .o_slot_b_word  (slot_b_word),
        .o_slot_b_pc    (slot_b_pc)
    );

    pair_decoder u_decoder (
        .i_slot_a_word (slot_a_word),
        .i_slot_a_pc   (slot_a_pc),
        .i_slot_b_word (slot_b_word),
        .i_slot_b_pc   (slot_b_pc),
        .o_dec_a       (dec_a),
        .o_dec_b       (dec_b)
    );

    issue_dispatch u_dispatch (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_slot_a_valid (slot_a_valid),
        .i_slot_b_valid (slot_b_valid),
        .i_dec_a        (dec_a),
        .i_dec_b        (dec_b),
        .i_exec_stall   (i_exec_stall),
        .o_issue_cnt    (issue_cnt),
        .o_issue_a      (issue_a),
        .o_issue_b      (issue_b)
    );

    exec_lane_regs u_lanes (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_exec_stall  (i_exec_stall),
        .i_issue_a     (issue_a),
        .i_issue_b     (issue_b),
        .i_dec_a       (dec_a),
        .i_dec_b       (dec_b),
        .o_lane0_valid (o_lane0_valid),
        .o_lane0_inst  (o_lane0_inst),
        .o_lane1_valid (o_lane1_valid),
        .o_lane1_inst  (o_lane1_inst)
    );

endmodule

//--- rtl/exec_lane_regs.sv
`timescale 1ns/100ps

module exec_lane_regs (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_exec_stall,
    input  logic                     i_issue_a,
    input  logic                     i_issue_b,
    input  issue_pkg::decoded_inst_t i_dec_a,
    input  issue_pkg::decoded_inst_t i_dec_b,
    output logic                     o_lane0_valid,
    output issue_pkg::decoded_inst_t o_lane0_inst,
    output logic                     o_lane1_valid,
    output issue_pkg::decoded_inst_t o_lane1_inst
);

    // Lane valids, an idle issue cycle loads zeros
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_lane0_valid <= 1'b0;
            o_lane1_valid <= 1'b0;
        end else if (!i_exec_stall) begin
            o_lane0_valid <= i_issue_a;
            o_lane1_valid <= i_issue_b;
        end
    end

    // Lane 0 always takes the older instruction
    always_ff @(posedge clk) begin
        if (!i_exec_stall) begin
            o_lane0_inst <= i_dec_a;
            o_lane1_inst <= i_dec_b;
        end
    end

endmodule

//--- rtl/inst_pair_buffer.sv
`timescale 1ns/100ps
`include "dispatch_params.svh"

module inst_pair_buffer (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_inst_valid,
    input  isa_pkg::inst_word_u   i_inst,
    input  issue_pkg::issue_cnt_t i_issue_cnt,
    output logic                  o_inst_ready,
    output logic                  o_slot_a_valid,
    output isa_pkg::inst_word_u   o_slot_a_word,
    output logic [31:0]           o_slot_a_pc,
    output logic                  o_slot_b_valid,
    output isa_pkg::inst_word_u   o_slot_b_word,
    output logic [31:0]           o_slot_b_pc
);
    import isa_pkg::*;

    localparam int PTR_W = $clog2(`BUF_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`BUF_DEPTH);

    inst_word_u       word_mem [`BUF_DEPTH];
    logic [31:0]      pc_mem [`BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_b;
    logic [CNT_W-1:0] count;
    logic [31:0]      next_pc;
    logic             push;

    assign o_inst_ready = (count != FULL_CNT);
    assign push         = i_inst_valid & o_inst_ready;

    // Two oldest entries, B follows A in program order
    assign rd_ptr_b       = rd_ptr + 1'b1;
    assign o_slot_a_valid = (count != '0);
    assign o_slot_b_valid = (count > CNT_W'(1));
    assign o_slot_a_word  = word_mem[rd_ptr];
    assign o_slot_a_pc    = pc_mem[rd_ptr];
    assign o_slot_b_word  = word_mem[rd_ptr_b];
    assign o_slot_b_pc    = pc_mem[rd_ptr_b];

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            next_pc <= `RESET_PC;
        end else begin
            if (push) begin
                wr_ptr  <= wr_ptr + 1'b1;
                next_pc <= next_pc + `PC_STEP;
            end
            // Retire what dispatch took, push and retire may overlap
            rd_ptr <= rd_ptr + PTR_W'(i_issue_cnt);
            count  <= count + CNT_W'(push) - CNT_W'(i_issue_cnt);
        end
    end

    // Word storage tagged with its PC
    always_ff @(posedge clk) begin
        if (push) begin
            word_mem[wr_ptr] <= i_inst;
            pc_mem[wr_ptr]   <= next_pc;
        end
    end

endmodule

//--- rtl/isa_pkg.sv
package isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes and instruction classes
    //////////////////////////////////////////////////////////////////////

    // All-zero word decodes as NOP
    typedef enum logic [5:0] {
        NOP  = 6'h00,
        ADD  = 6'h01,
        SUB  = 6'h02,
        AND  = 6'h03,
        OR   = 6'h04,
        ADDI = 6'h08,
        MUL  = 6'h0c,
        DIV  = 6'h0d,
        LD   = 6'h10,
        ST   = 6'h11,
        B    = 6'h14,
        BEQ  = 6'h16,
        BNE  = 6'h17
    } opcode_e;

    typedef enum logic [2:0] {
        ALU    = 3'd0,
        BRANCH = 3'd1,
        LOAD   = 3'd2,
        STORE  = 3'd3,
        MULDIV = 3'd4
    } inst_class_e;

    //////////////////////////////////////////////////////////////////////
    // Instruction word views
    //////////////////////////////////////////////////////////////////////

    // Register-register format
    typedef struct packed {
        opcode_e     opcode;
        logic [10:0] spare;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_reg_view_t;

    // 12-bit immediate format
    typedef struct packed {
        opcode_e     opcode;
        logic [3:0]  spare;
        logic [11:0] imm;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_imm_view_t;

    typedef union packed {
        inst_reg_view_t r;
        inst_imm_view_t i;
    } inst_word_u;

endpackage

//--- rtl/issue_dispatch.sv
`timescale 1ns/100ps

module issue_dispatch (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_slot_a_valid,
    input  logic                     i_slot_b_valid,
    input  issue_pkg::decoded_inst_t i_dec_a,
    input  issue_pkg::decoded_inst_t i_dec_b,
    input  logic                     i_exec_stall,
    output issue_pkg::issue_cnt_t    o_issue_cnt,
    output logic                     o_issue_a,
    output logic                     o_issue_b
);
    import isa_pkg::*;
    import issue_pkg::*;

    // Load issued in the previous cycle
    logic       last_ld;
    logic [4:0] last_rd;

    logic lock_a;
    logic lock_b;
    logic a_not_alu;
    logic double_br;
    logic raw_ab;
    logic load_a;
    logic load_b;

    // Source match through rj, or through rk when the op uses it
    function automatic logic reads_reg(decoded_inst_t d, logic [4:0] r);
        return (d.rj == r) || (d.reads_rk && (d.rk == r));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Pairing rules
    //////////////////////////////////////////////////////////////////////

    assign lock_a    = last_ld && reads_reg(i_dec_a, last_rd);
    assign lock_b    = last_ld && reads_reg(i_dec_b, last_rd);
    assign a_not_alu = (i_dec_a.inst_class != ALU);
    assign double_br = (i_dec_a.inst_class == BRANCH) && (i_dec_b.inst_class == BRANCH);
    // r0 never carries a dependency
    assign raw_ab    = i_dec_a.writes_rd && (i_dec_a.rd != '0)
                       && reads_reg(i_dec_b, i_dec_a.rd);

    always_comb begin
        o_issue_a = 1'b0;
        o_issue_b = 1'b0;
        if (i_slot_a_valid && !i_exec_stall && !lock_a) begin
            o_issue_a = 1'b1;
            o_issue_b = i_slot_b_valid && !lock_b && !a_not_alu
                        && !double_br && !raw_ab;
        end
    end

    assign o_issue_cnt = issue_cnt_t'(o_issue_a) + issue_cnt_t'(o_issue_b);

    //////////////////////////////////////////////////////////////////////
    // Load-use interlock state
    //////////////////////////////////////////////////////////////////////

    assign load_a = o_issue_a && (i_dec_a.inst_class == LOAD) && (i_dec_a.rd != '0);
    assign load_b = o_issue_b && (i_dec_b.inst_class == LOAD) && (i_dec_b.rd != '0);

    // Rewritten every cycle, so an idle cycle drops the interlock
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            last_ld <= 1'b0;
            last_rd <= '0;
        end else begin
            last_ld <= load_a | load_b;
            last_rd <= load_a ? i_dec_a.rd : i_dec_b.rd;
        end
    end

endmodule

//--- rtl/issue_pkg.sv
package issue_pkg;

    //////////////////////////////////////////////////////////////////////
    // Decoded instruction as seen by dispatch and the lanes
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        isa_pkg::inst_class_e inst_class;
        logic [4:0]           rd;
        logic [4:0]           rj;
        // Second source, also carries rd for stores and compare branches
        logic [4:0]           rk;
        logic                 reads_rk;
        logic                 writes_rd;
        logic [11:0]          imm;
        logic [31:0]          pc;
    } decoded_inst_t;

    // Instructions taken from the buffer head this cycle, 0 to 2
    typedef logic [1:0] issue_cnt_t;

endpackage

//--- rtl/pair_decoder.sv
`timescale 1ns/100ps

module pair_decoder (
    input  isa_pkg::inst_word_u      i_slot_a_word,
    input  logic [31:0]              i_slot_a_pc,
    input  isa_pkg::inst_word_u      i_slot_b_word,
    input  logic [31:0]              i_slot_b_pc,
    output issue_pkg::decoded_inst_t o_dec_a,
    output issue_pkg::decoded_inst_t o_dec_b
);
    import isa_pkg::*;
    import issue_pkg::*;

    function automatic decoded_inst_t decode(inst_word_u w, logic [31:0] pc);
        decoded_inst_t d;
        d.inst_class = ALU;
        d.rd         = w.r.rd;
        d.rj         = w.r.rj;
        d.rk         = '0;
        d.reads_rk   = 1'b0;
        d.writes_rd  = 1'b0;
        d.imm        = '0;
        d.pc         = pc;
        case (w.r.opcode)
            ADD, SUB, AND, OR: begin
                d.rk        = w.r.rk;
                d.reads_rk  = 1'b1;
                d.writes_rd = 1'b1;
            end
            ADDI: begin
                d.imm       = w.i.imm;
                d.writes_rd = 1'b1;
            end
            MUL, DIV: begin
                d.inst_class = MULDIV;
                d.rk         = w.r.rk;
                d.reads_rk   = 1'b1;
                d.writes_rd  = 1'b1;
            end
            LD: begin
                d.inst_class = LOAD;
                d.imm        = w.i.imm;
                d.writes_rd  = 1'b1;
            end
            // Store data register sits in rd, read through the rk slot
            ST: begin
                d.inst_class = STORE;
                d.imm        = w.i.imm;
                d.rk         = w.i.rd;
                d.reads_rk   = 1'b1;
            end
            // Compare branches test rj against rd
            BEQ, BNE: begin
                d.inst_class = BRANCH;
                d.imm        = w.i.imm;
                d.rk         = w.i.rd;
                d.reads_rk   = 1'b1;
            end
            B: begin
                d.inst_class = BRANCH;
                d.imm        = w.i.imm;
            end
            // NOP and unknown opcodes behave as an ALU op with no write
            default: begin
                d.inst_class = ALU;
            end
        endcase
        return d;
    endfunction

    assign o_dec_a = decode(i_slot_a_word, i_slot_a_pc);
    assign o_dec_b = decode(i_slot_b_word, i_slot_b_pc);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_dual_issue \
    -f project.f \
    -o sim_tb

./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failures"

//--- verif/dispatch_input.txt
// block  word  lane  pair  idle, all hex; pair 1 means issued with the previous word
// idle is the count of empty lane cycles before the word inside its block; ff ends the list
0 04000C41 0 0 0  // add  r1, r2, r3
0 080018A4 1 1 0  // sub  r4, r5, r6
0 40004107 0 0 0  // ld   r7, 0x10(r8)
0 300039AC 0 0 0  // mul  r12, r13, r14
0 4400120F 0 0 0  // st   r15, 4(r16)
0 340058B4 0 0 0  // div  r20, r21, r22
1 04000C41 0 0 0  // add  r1, r2, r3
1 08001424 0 0 0  // sub  r4, r1, r5
1 04001C80 0 0 0  // add  r0, r4, r7
1 0800340C 1 1 0  // sub  r12, r0, r13
1 580021CF 0 0 0  // beq  r14, r15
1 5C004211 0 0 0  // bne  r16, r17
1 04005272 0 0 0  // add  r18, r19, r20
2 40000025 0 0 0  // ld   r5, 0(r1)
2 040008A6 0 0 1  // add  r6, r5, r2
2 10002507 1 1 0  // or   r7, r8, r9
2 4000106A 0 0 0  // ld   r10, 4(r3)
2 0400358B 0 0 0  // add  r11, r12, r13
2 0C004E51 1 1 0  // and  r17, r18, r19
3 40000034 0 0 0  // ld   r20, 0(r1)
3 04005ED5 0 0 0  // add  r21, r22, r23
3 08006698 0 0 0  // sub  r24, r20, r25
3 201FFF7A 1 1 0  // addi r26, r27, 0x7ff
3 04007BBC 0 0 0  // add  r28, r29, r30
3 58008043 1 1 0  // beq  r2, r3
3 4400201C 0 0 0  // st   r28, 8(r0)
3 50040000 0 0 0  // b    0x100
ff 00000000 0 0 0

//--- verif/tb_dual_issue.sv
`timescale 1ns/100ps
`include "dispatch_params.svh"

module tb_dual_issue;
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYLES_UNUSED_GUARD = 0;
    localparam int RESET_CYCLES = 5;
    // Stimulus line columns are block, word, lane, pair and idle
    localparam int COLS      = 5;
    localparam int MAX_LINES = 100;

    logic          clk;
    logic          i_arst_n;
    logic          i_inst_valid;
    inst_word_u    i_inst;
    logic          i_exec_stall;
    logic          o_inst_ready;
    logic          o_lane0_valid;
    decoded_inst_t o_lane0_inst;
    logic          o_lane1_valid;
    decoded_inst_t o_lane1_inst;

    logic [31:0]   vec_mem [512];
    int            n_inst   = 0;
    int            seen_cnt = 0;
    int            idle_run = 0;
    integer        seed;
    logic          loaded   = 1'b0;
    logic          stall_q;
    logic          hold_v0  = 1'b0;
    logic          hold_v1  = 1'b0;
    decoded_inst_t hold_i0;
    decoded_inst_t hold_i1;

    dual_issue_top u_dual_issue_top (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_inst_valid  (i_inst_valid),
        .i_inst        (i_inst),
        .i_exec_stall  (i_exec_stall),
        .o_inst_ready  (o_inst_ready),
        .o_lane0_valid (o_lane0_valid),
        .o_lane0_inst  (o_lane0_inst),
        .o_lane1_valid (o_lane1_valid),
        .o_lane1_inst  (o_lane1_inst)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] vec_field(int line, int col);
        return vec_mem[9'(line * COLS + col)];
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic expect_equal(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Instruction classes and immediates from the major opcode
    //////////////////////////////////////////////////////////////////////

    function automatic inst_class_e class_of(logic [5:0] opcode);
        case (opcode_e'(opcode))
            MUL, DIV:    return MULDIV;
            LD:          return LOAD;
            ST:          return STORE;
            BEQ, BNE, B: return BRANCH;
            default:     return ALU;
        endcase
    endfunction

    function automatic logic has_imm(logic [5:0] opcode);
        case (opcode_e'(opcode))
            ADDI, LD, ST, BEQ, BNE, B: return 1'b1;
            default:                   return 1'b0;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Lane monitor
    //////////////////////////////////////////////////////////////////////

    // Stall as the lanes saw it on the last rising edge
    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= i_exec_stall;
        end
    end

    task automatic check_lane(decoded_inst_t inst, int lane);
        logic [31:0] exp_pc;
        logic [31:0] word;
        logic [11:0] exp_imm;
        string       name;
        assert (seen_cnt < n_inst) else begin
            $display("lane %0d issued more instructions than were pushed", lane);
            abort_run();
        end
        name = $sformatf("o_lane%0d_inst", lane);
        word = vec_field(seen_cnt, 1);
        // PCs follow push order from the reset PC
        exp_pc = `RESET_PC + `PC_STEP * 32'(seen_cnt);
        expect_equal({name, ".pc"}, 64'(inst.pc), 64'(exp_pc));
        // Register and immediate fields straight from the word layout
        exp_imm = has_imm(word[31:26]) ? word[21:10] : 12'h000;
        expect_equal({name, ".inst_class"}, 64'(inst.inst_class),
                     64'(class_of(word[31:26])));
        expect_equal({name, ".rd"}, 64'(inst.rd), 64'(word[4:0]));
        expect_equal({name, ".rj"}, 64'(inst.rj), 64'(word[9:5]));
        expect_equal({name, ".imm"}, 64'(inst.imm), 64'(exp_imm));
        expect_equal("lane number", 64'(lane), 64'(vec_field(seen_cnt, 2)));
        expect_equal("pair flag", 64'(lane == 1), 64'(vec_field(seen_cnt, 3)));
        // Gaps only count inside a block
        if (lane == 0 && seen_cnt > 0
                && vec_field(seen_cnt, 0) == vec_field(seen_cnt - 1, 0)) begin
            expect_equal("idle lane cycles", 64'(idle_run), 64'(vec_field(seen_cnt, 4)));
        end
        seen_cnt = seen_cnt + 1;
    endtask

    always @(negedge clk) begin
        if (stall_q) begin
            expect_equal("o_lane0_valid", 64'(o_lane0_valid), 64'(hold_v0));
            expect_equal("o_lane1_valid", 64'(o_lane1_valid), 64'(hold_v1));
            expect_equal("o_lane0_inst", 64'(o_lane0_inst), 64'(hold_i0));
            expect_equal("o_lane1_inst", 64'(o_lane1_inst), 64'(hold_i1));
        end else if (o_lane0_valid) begin
            check_lane(o_lane0_inst, 0);
            if (o_lane1_valid) begin
                check_lane(o_lane1_inst, 1);
            end
            idle_run = 0;
        end else begin
            assert (!o_lane1_valid) else begin
                $display("lane 1 holds an instruction while lane 0 is empty");
                abort_run();
            end
            idle_run = idle_run + 1;
        end
        hold_v0 = o_lane0_valid;
        hold_v1 = o_lane1_valid;
        hold_i0 = o_lane0_inst;
        hold_i1 = o_lane1_inst;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Fill the buffer under stall, then let the block drain
    task automatic push_block(int first, int last);
        int n;
        n = last - first + 1;
        assert (n <= `BUF_DEPTH) else begin
            $display("a stimulus block holds more words than the buffer");
            abort_run();
        end
        // Raised while the last lane contents of the previous block are still valid
        i_exec_stall = 1'b1;
        for (int k = first; k <= last; k++) begin
            expect_equal("o_inst_ready", 64'(o_inst_ready), 64'(1));
            i_inst_valid = 1'b1;
            i_inst       = vec_field(k, 1);
            @(negedge clk);
        end
        i_inst_valid = 1'b0;
        expect_equal("o_inst_ready", 64'(o_inst_ready), 64'(n < `BUF_DEPTH));
        if (n == `BUF_DEPTH) begin
            // Offered while full, so it must never show up in a lane
            i_inst_valid = 1'b1;
            i_inst       = inst_word_u'($random(seed));
            @(negedge clk);
            i_inst_valid = 1'b0;
        end
        i_exec_stall = 1'b0;
    endtask

    initial begin
        int first;
        int last;
        i_arst_n     = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_exec_stall = 1'b0;
        seed         = 32'h49e4;
        $readmemh("verif/dispatch_input.txt", vec_mem);
        while (n_inst < MAX_LINES && vec_field(n_inst, 0) != 32'hff) begin
            n_inst = n_inst + 1;
        end
        assert (n_inst > 0) else begin
            $display("no instructions found in verif/dispatch_input.txt");
            abort_run();
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        first = 0;
        while (first < n_inst) begin
            last = first;
            while (last + 1 < n_inst && vec_field(last + 1, 0) == vec_field(first, 0)) begin
                last = last + 1;
            end
            push_block(first, last);
            wait (seen_cnt == last + 1);
            first = last + 1;
        end
        // Quiet tail where the monitor still catches a late lane valid
        repeat (4) @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        repeat (40 * n_inst + 100) @(posedge clk);
        $display("timed out waiting for all instructions to reach the lanes");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
